// ==== tests/rv_core_tests.mem ====
// word 0 program length, word 1 store count
// then program words from address 0, then one store address and data pair per line
0000001D
0000000A
10000513 // 00 addi x10, x0, 0x100
123450B7 // 04 lui  x1, 0x12345
67808093 // 08 addi x1, x1, 0x678
0F000113 // 0c addi x2, x0, 0x0f0
FFD00193 // 10 addi x3, x0, -3
00208233 // 14 add  x4, x1, x2
403102B3 // 18 sub  x5, x2, x3
0020F333 // 1c and  x6, x1, x2
0020E3B3 // 20 or   x7, x1, x2
0030C433 // 24 xor  x8, x1, x3
00208033 // 28 add  x0, x1, x2
00152023 // 2c sw   x1, 0(x10)
00452223 // 30 sw   x4, 4(x10)
00552423 // 34 sw   x5, 8(x10)
00652623 // 38 sw   x6, 12(x10)
00752823 // 3c sw   x7, 16(x10)
00852A23 // 40 sw   x8, 20(x10)
00052C23 // 44 sw   x0, 24(x10)
00052483 // 48 lw   x9, 0(x10)
01048493 // 4c addi x9, x9, 16
00952E23 // 50 sw   x9, 28(x10)
00108463 // 54 beq  x1, x1, +8
02352023 // 58 sw   x3, 32(x10)   skipped
00109463 // 5c bne  x1, x1, +8    not taken
02252023 // 60 sw   x2, 32(x10)
008005EF // 64 jal  x11, +8
02352223 // 68 sw   x3, 36(x10)   skipped
02B52223 // 6c sw   x11, 36(x10)
0000006F // 70 jal  x0, 0
00000100 12345678
00000104 12345768
00000108 000000F3
0000010C 00000070
00000110 123456F8
00000114 EDCBA985
00000118 00000000
0000011C 12345688
00000120 000000F0
00000124 00000068

// ==== list.f ====
src/rv_pkg.sv
src/reg_file.sv
src/fetch_unit.sv
src/exec_unit.sv
src/lsu.sv
src/bus_arbiter.sv
src/rv_core.sv
tests/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/reg_file.sv
  - src/fetch_unit.sv
  - src/exec_unit.sv
  - src/lsu.sv
  - src/bus_arbiter.sv
  - src/rv_core.sv
  - target: test
    files:
      - tests/tb_rv_core.sv

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam int unsigned CLK_PERIOD      = 100;
    localparam int unsigned RESET_CYCLES    = 8;
    localparam int unsigned MEM_DEPTH       = 128;
    localparam int unsigned TESTS_DEPTH     = 256;
    localparam int unsigned DATA_BASE       = 32'h100;
    localparam int unsigned WATCHDOG_FACTOR = 200;
    localparam int unsigned SETTLE_CYCLES   = 20;
    localparam logic [15:0] LFSR_SEED       = 16'd13004;

    logic                    clk;
    logic                    rst_n_i;
    logic                    wb_cyc_o;
    logic                    wb_stb_o;
    logic                    wb_we_o;
    logic [rv_pkg::XLEN-1:0] wb_adr_o;
    logic [rv_pkg::XLEN-1:0] wb_dat_o;
    logic [rv_pkg::XLEN-1:0] wb_dat_i = '0;
    logic                    wb_ack_i = 1'b0;

    logic [31:0] tests_mem [TESTS_DEPTH];
    logic [31:0] mem [MEM_DEPTH];
    logic [15:0] lfsr_q       = LFSR_SEED;
    int unsigned prog_len     = 0;
    int unsigned exp_count    = 0;
    int unsigned store_cnt    = 0;
    int unsigned run_cycles   = 0;
    int unsigned reset_edges  = 0;
    int unsigned wait_left    = 0;
    logic        pending      = 1'b0;
    logic        first_seen   = 1'b0;
    logic        tests_loaded = 1'b0;

    rv_core i_dut (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    // wait states from two lfsr bits
    task automatic draw_wait(output int unsigned cycles);
        logic b0;
        logic b1;
        b0     = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        b1     = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        cycles = {b1, b0};
    endtask

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_address(input logic [31:0] adr);
        logic in_prog;
        logic in_data;
        in_prog = adr < prog_len * 4;
        in_data = adr >= DATA_BASE && adr < MEM_DEPTH * 4;
        if (adr[1:0] != 2'b00 || !(in_prog || in_data)) begin
            $display("bus access at %0d ns to address %h is outside the program and data area",
                     $time, adr);
            abort_run();
        end
    endtask

    task automatic load_tests();
        $readmemh("tests/rv_core_tests.mem", tests_mem);
        prog_len  = tests_mem[0];
        exp_count = tests_mem[1];
        if ($isunknown(tests_mem[0]) || $isunknown(tests_mem[1]) ||
            prog_len == 0 || exp_count == 0 || prog_len * 4 > DATA_BASE ||
            2 + prog_len + 2 * exp_count > TESTS_DEPTH) begin
            $display("test data file is missing or its counts do not fit the memory");
            abort_run();
        end else begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] = 32'hC0DE_0000 ^ (i << 2);
            end
            // program from address 0
            for (int i = 0; i < prog_len; i++) begin
                mem[i] = tests_mem[2 + i];
            end
        end
    endtask

    // ack plus read data, and the in-order store check
    task automatic finish_access();
        int unsigned idx;
        int unsigned pair;
        idx      = wb_adr_o[8:2];
        pair     = 2 + prog_len + 2 * store_cnt;
        pending  = 1'b0;
        wb_ack_i <= 1'b1;
        wb_dat_i <= mem[idx];
        if (wb_we_o) begin
            if (store_cnt >= exp_count) begin
                $display("unexpected extra store to %h at %0d ns", wb_adr_o, $time);
                abort_run();
            end else begin
                check_value("wb_adr_o", wb_adr_o, tests_mem[pair]);
                check_value("wb_dat_o", wb_dat_o, tests_mem[pair + 1]);
                mem[idx] = wb_dat_o;
                store_cnt++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // wishbone memory model
    always @(posedge clk) begin
        if (!rst_n_i) begin
            // flops are still unknown before the first edge
            if (reset_edges > 0) begin
                check_value("wb_cyc_o", wb_cyc_o, 1'b0);
                check_value("wb_stb_o", wb_stb_o, 1'b0);
            end
            reset_edges++;
            pending = 1'b0;
            wb_ack_i <= 1'b0;
        end else begin
            if (wb_ack_i) begin
                wb_ack_i <= 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (!pending) begin
                    if (!first_seen) begin
                        check_value("first wb_stb_o cycle", run_cycles, 1);
                        check_value("wb_adr_o", wb_adr_o, rv_pkg::RESET_PC);
                        check_value("wb_we_o", wb_we_o, 1'b0);
                        first_seen = 1'b1;
                    end
                    check_address(wb_adr_o);
                    draw_wait(wait_left);
                    pending = 1'b1;
                end
                if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    finish_access();
                end
            end
            run_cycles++;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        wait (store_cnt == exp_count);
        // final loop keeps running, so stray stores still show up
        repeat (SETTLE_CYCLES) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

    initial begin
        wait (tests_loaded);
        repeat (RESET_CYCLES + prog_len * WATCHDOG_FACTOR) @(posedge clk);
        $display("watchdog: the program did not finish its %0d stores in time, %0d seen",
                 exp_count, store_cnt);
        abort_run();
    end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst_n_i,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output logic [rv_pkg::XLEN-1:0] wb_adr_o,
    output logic [rv_pkg::XLEN-1:0] wb_dat_o,
    input  logic [rv_pkg::XLEN-1:0] wb_dat_i,
    input  logic                    wb_ack_i
);

    // fetch side
    logic                          fetch_req, fetch_ack;
    logic [rv_pkg::XLEN-1:0]       fetch_adr, fetch_rdata;
    logic                          instr_valid, instr_take, redirect;
    logic [rv_pkg::XLEN-1:0]       instr, instr_pc, redirect_pc;

    // data side
    logic                          data_req, data_we, data_ack;
    logic [rv_pkg::XLEN-1:0]       data_adr, data_wdata, data_rdata;
    logic                          mem_start, mem_we, mem_done;
    logic [rv_pkg::XLEN-1:0]       mem_adr, mem_wdata, mem_rdata;

    logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr, rf_waddr;
    logic [rv_pkg::XLEN-1:0]       rs1_data, rs2_data, rf_wdata;
    logic                          rf_we;

    fetch_unit fetch_ins (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_take_i(instr_take), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .fetch_req_o(fetch_req), .fetch_adr_o(fetch_adr),
        .fetch_ack_i(fetch_ack), .fetch_rdata_i(fetch_rdata),
        .instr_valid_o(instr_valid), .instr_o(instr), .instr_pc_o(instr_pc)
    );

    exec_unit exec_ins (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid), .instr_i(instr), .instr_pc_i(instr_pc),
        .instr_take_o(instr_take), .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .mem_start_o(mem_start), .mem_we_o(mem_we),
        .mem_adr_o(mem_adr), .mem_wdata_o(mem_wdata),
        .mem_done_i(mem_done), .mem_rdata_i(mem_rdata)
    );

    reg_file regs_ins (
        .clk(clk),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    lsu lsu_ins (
        .clk(clk), .rst_n_i(rst_n_i),
        .mem_start_i(mem_start), .mem_we_i(mem_we),
        .mem_adr_i(mem_adr), .mem_wdata_i(mem_wdata),
        .mem_done_o(mem_done), .mem_rdata_o(mem_rdata),
        .data_req_o(data_req), .data_we_o(data_we),
        .data_adr_o(data_adr), .data_wdata_o(data_wdata),
        .data_ack_i(data_ack), .data_rdata_i(data_rdata)
    );

    bus_arbiter arb_ins (
        .clk(clk), .rst_n_i(rst_n_i),
        .fetch_req_i(fetch_req), .fetch_adr_i(fetch_adr),
        .fetch_ack_o(fetch_ack), .fetch_rdata_o(fetch_rdata),
        .data_req_i(data_req), .data_we_i(data_we),
        .data_adr_i(data_adr), .data_wdata_i(data_wdata),
        .data_ack_o(data_ack), .data_rdata_o(data_rdata),
        .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
    );

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    fetch_req_i,
    input  logic [rv_pkg::XLEN-1:0] fetch_adr_i,
    output logic                    fetch_ack_o,
    output logic [rv_pkg::XLEN-1:0] fetch_rdata_o,
    input  logic                    data_req_i,
    input  logic                    data_we_i,
    input  logic [rv_pkg::XLEN-1:0] data_adr_i,
    input  logic [rv_pkg::XLEN-1:0] data_wdata_i,
    output logic                    data_ack_o,
    output logic [rv_pkg::XLEN-1:0] data_rdata_o,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output logic [rv_pkg::XLEN-1:0] wb_adr_o,
    output logic [rv_pkg::XLEN-1:0] wb_dat_o,
    input  logic [rv_pkg::XLEN-1:0] wb_dat_i,
    input  logic                    wb_ack_i
);

    rv_pkg::arb_state_e state_q;

    // owner requests are held stable, so the bus fields can be muxed
    assign wb_adr_o = (state_q == rv_pkg::ARB_DATA) ? data_adr_i : fetch_adr_i;
    assign wb_dat_o = data_wdata_i;
    assign wb_we_o  = (state_q == rv_pkg::ARB_DATA) && data_we_i;

    assign fetch_ack_o   = (state_q == rv_pkg::ARB_FETCH) && wb_ack_i;
    assign data_ack_o    = (state_q == rv_pkg::ARB_DATA) && wb_ack_i;
    assign fetch_rdata_o = wb_dat_i;
    assign data_rdata_o  = wb_dat_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q  <= rv_pkg::ARB_IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
        end else if (state_q == rv_pkg::ARB_IDLE) begin
            // data first
            if (data_req_i) begin
                state_q <= rv_pkg::ARB_DATA;
            end else if (fetch_req_i) begin
                state_q <= rv_pkg::ARB_FETCH;
            end
            wb_cyc_o <= data_req_i || fetch_req_i;
            wb_stb_o <= data_req_i || fetch_req_i;
        end else if (wb_ack_i) begin
            state_q  <= rv_pkg::ARB_IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_i |-> wb_cyc_o && wb_stb_o);

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o) && $stable(wb_we_o));

endmodule

// ==== src/lsu.sv ====
`timescale 1ns/1ps

module lsu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    mem_start_i,
    input  logic                    mem_we_i,
    input  logic [rv_pkg::XLEN-1:0] mem_adr_i,
    input  logic [rv_pkg::XLEN-1:0] mem_wdata_i,
    output logic                    mem_done_o,
    output logic [rv_pkg::XLEN-1:0] mem_rdata_o,
    output logic                    data_req_o,
    output logic                    data_we_o,
    output logic [rv_pkg::XLEN-1:0] data_adr_o,
    output logic [rv_pkg::XLEN-1:0] data_wdata_o,
    input  logic                    data_ack_i,
    input  logic [rv_pkg::XLEN-1:0] data_rdata_i
);

    logic busy_q;
    logic done_q;

    assign data_req_o = busy_q;
    assign mem_done_o = done_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= busy_q && data_ack_i;
            if (mem_start_i) begin
                busy_q <= 1'b1;
            end else if (data_ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // access fields and load data
    always_ff @(posedge clk) begin
        if (mem_start_i) begin
            data_we_o    <= mem_we_i;
            data_adr_o   <= mem_adr_i;
            data_wdata_o <= mem_wdata_i;
        end
        if (busy_q && data_ack_i) begin
            mem_rdata_o <= data_rdata_i;
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_start_i |-> !busy_q);

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          instr_valid_i,
    input  logic [rv_pkg::XLEN-1:0]       instr_i,
    input  logic [rv_pkg::XLEN-1:0]       instr_pc_i,
    output logic                          instr_take_o,
    output logic                          redirect_o,
    output logic [rv_pkg::XLEN-1:0]       redirect_pc_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
    output logic                          rf_we_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [rv_pkg::XLEN-1:0]       rf_wdata_o,
    output logic                          mem_start_o,
    output logic                          mem_we_o,
    output logic [rv_pkg::XLEN-1:0]       mem_adr_o,
    output logic [rv_pkg::XLEN-1:0]       mem_wdata_o,
    input  logic                          mem_done_i,
    input  logic [rv_pkg::XLEN-1:0]       mem_rdata_i
);

    rv_pkg::opcode_e         opcode;
    rv_pkg::exec_state_e     state_q, state_d;
    logic [2:0]              funct3;
    logic [rv_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [rv_pkg::XLEN-1:0] op_b, alu_res;
    logic                    is_mem, writes_rd, br_taken, jump_taken;

    assign opcode     = rv_pkg::opcode_e'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rf_waddr_o = instr_i[11:7];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    assign op_b = (opcode == rv_pkg::OPC_OP) ? rs2_data_i : imm_i;

    always_comb begin
        case (funct3)
            3'b100:  alu_res = rs1_data_i ^ op_b;
            3'b110:  alu_res = rs1_data_i | op_b;
            3'b111:  alu_res = rs1_data_i & op_b;
            // sub only for register-register ops
            default: alu_res = (opcode == rv_pkg::OPC_OP && instr_i[30]) ?
                               rs1_data_i - op_b : rs1_data_i + op_b;
        endcase
    end

    // beq on funct3 000, bne on 001
    assign br_taken = (funct3 == 3'b000) ? (rs1_data_i == rs2_data_i) :
                      (funct3 == 3'b001) ? (rs1_data_i != rs2_data_i) : 1'b0;

    always_comb begin
        is_mem     = 1'b0;
        writes_rd  = 1'b0;
        jump_taken = 1'b0;
        rf_wdata_o = alu_res;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                writes_rd  = 1'b1;
                rf_wdata_o = imm_u;
            end
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: writes_rd = 1'b1;
            rv_pkg::OPC_LOAD: begin
                is_mem     = 1'b1;
                rf_wdata_o = mem_rdata_i;
            end
            rv_pkg::OPC_STORE:  is_mem = 1'b1;
            rv_pkg::OPC_BRANCH: jump_taken = br_taken;
            rv_pkg::OPC_JAL: begin
                writes_rd  = 1'b1;
                jump_taken = 1'b1;
                rf_wdata_o = instr_pc_i + 32'd4;
            end
            default: ;
        endcase
    end

    assign redirect_pc_o = instr_pc_i + ((opcode == rv_pkg::OPC_JAL) ? imm_j : imm_b);
    assign mem_we_o      = (opcode == rv_pkg::OPC_STORE);
    assign mem_adr_o     = rs1_data_i + (mem_we_o ? imm_s : imm_i);
    assign mem_wdata_o   = rs2_data_i;

    always_comb begin
        state_d      = state_q;
        instr_take_o = 1'b0;
        redirect_o   = 1'b0;
        rf_we_o      = 1'b0;
        mem_start_o  = 1'b0;
        case (state_q)
            rv_pkg::EXEC_RUN: begin
                if (instr_valid_i && is_mem) begin
                    mem_start_o = 1'b1;
                    state_d     = rv_pkg::EXEC_WAIT_MEM;
                end else if (instr_valid_i) begin
                    instr_take_o = 1'b1;
                    rf_we_o      = writes_rd;
                    redirect_o   = jump_taken;
                end
            end
            rv_pkg::EXEC_WAIT_MEM: begin
                if (mem_done_i) begin
                    instr_take_o = 1'b1;
                    rf_we_o      = ~mem_we_o;
                    state_d      = rv_pkg::EXEC_RUN;
                end
            end
            default: state_d = rv_pkg::EXEC_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= rv_pkg::EXEC_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_done_i |-> state_q == rv_pkg::EXEC_WAIT_MEM);

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    instr_take_i,
    input  logic                    redirect_i,
    input  logic [rv_pkg::XLEN-1:0] redirect_pc_i,
    output logic                    fetch_req_o,
    output logic [rv_pkg::XLEN-1:0] fetch_adr_o,
    input  logic                    fetch_ack_i,
    input  logic [rv_pkg::XLEN-1:0] fetch_rdata_i,
    output logic                    instr_valid_o,
    output logic [rv_pkg::XLEN-1:0] instr_o,
    output logic [rv_pkg::XLEN-1:0] instr_pc_o
);

    logic                    buf_valid_q;
    logic [rv_pkg::XLEN-1:0] fetch_adr_q;
    logic [rv_pkg::XLEN-1:0] buf_instr_q;
    logic [rv_pkg::XLEN-1:0] buf_pc_q;

    // fetch whenever the buffer is empty
    assign fetch_req_o   = ~buf_valid_q;
    assign fetch_adr_o   = fetch_adr_q;
    assign instr_valid_o = buf_valid_q;
    assign instr_o       = buf_instr_q;
    assign instr_pc_o    = buf_pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            buf_valid_q <= 1'b0;
            fetch_adr_q <= rv_pkg::RESET_PC;
        end else begin
            if (fetch_ack_i) begin
                buf_valid_q <= 1'b1;
                fetch_adr_q <= fetch_adr_q + 32'd4;
            end
            // a redirect comes with a full buffer, never during a fetch
            if (redirect_i) begin
                buf_valid_q <= 1'b0;
                fetch_adr_q <= redirect_pc_i;
            end else if (instr_take_i) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ack_i) begin
            buf_instr_q <= fetch_rdata_i;
            buf_pc_q    <= fetch_adr_q;
        end
    end

    a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_req_o && !fetch_ack_i |=> fetch_req_o && $stable(fetch_adr_o));

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

    // x0 is hardwired to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [0:0] {
        EXEC_RUN      = 1'b0,
        EXEC_WAIT_MEM = 1'b1
    } exec_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_FETCH = 2'd1,
        ARB_DATA  = 2'd2
    } arb_state_e;

endpackage
